//--- common/soc_pkg.sv
package soc_pkg;

    // host bus widths
    typedef logic [31:0] bus_addr_t;
    typedef logic [31:0] bus_data_t;

    // one bit per byte lane
    typedef logic [3:0] bus_mask_t;

    // single-word request from the host
    // ren/wen are one-cycle strobes
    typedef struct packed {
        bus_addr_t addr;
        bus_data_t wdata;
        bus_mask_t wmask;
        logic      wen;
        logic      ren;
    } bus_req_t;

    // answer to a request, rdata only valid while done is high
    typedef struct packed {
        bus_data_t rdata;
        logic      done;
    } bus_rsp_t;

    // HUB75 panel pins
    // two color triplets for the upper and lower half of the panel
    typedef struct packed {
        logic r0;
        logic g0;
        logic b0;
        logic r1;
        logic g1;
        logic b1;
        // row select
        logic row_a;
        logic row_b;
        logic row_c;
        logic row_d;
        logic row_e;
        // shift clock, latch strobe, output enable
        logic clk;
        logic stb;
        logic oe;
    } hub75_pins_t;

    // byte address of the parallel output word
    localparam bus_addr_t PP_BASE = 32'h0010_0000;

endpackage

//--- hdl/bus_hub.sv
`timescale 1ns/1ns

module bus_hub (
    input  logic              core_clk,
    input  logic              arst_n,

    // host side
    input  soc_pkg::bus_req_t host_req,
    output soc_pkg::bus_rsp_t host_rsp,

    // data memory
    output soc_pkg::bus_req_t mem_req,
    input  soc_pkg::bus_rsp_t mem_rsp,
    input  logic              mem_active,

    // parallel output port
    output soc_pkg::bus_req_t pp_req,
    input  soc_pkg::bus_rsp_t pp_rsp,
    input  logic              pp_active
);

    // which device answers in the next cycle
    typedef enum logic [1:0] {
        sel_none,
        sel_mem,
        sel_pp
    } sel_e;

    sel_e sel_d;
    sel_e sel_q;
    logic strobe;
    logic strobe_q;
    logic mem_hit;
    logic pp_hit;

    assign strobe = host_req.ren | host_req.wen;

    // memory wins if both devices claim the address
    assign mem_hit = mem_active;
    assign pp_hit  = pp_active & ~mem_active;

    // request fans out to both devices, strobes only to the one that claims it
    always_comb begin
        mem_req     = host_req;
        mem_req.ren = host_req.ren & mem_hit;
        mem_req.wen = host_req.wen & mem_hit;

        pp_req      = host_req;
        pp_req.ren  = host_req.ren & pp_hit;
        pp_req.wen  = host_req.wen & pp_hit;
    end

    // target of the current request
    always_comb begin
        if (mem_hit) begin
            sel_d = sel_mem;
        end else if (pp_hit) begin
            sel_d = sel_pp;
        end else begin
            sel_d = sel_none;
        end
    end

    // selector falls back to none between requests
    always_ff @(posedge core_clk or negedge arst_n) begin
        if (!arst_n) begin
            sel_q    <= sel_none;
            strobe_q <= 1'b0;
        end else begin
            sel_q    <= strobe ? sel_d : sel_none;
            strobe_q <= strobe;
        end
    end

    // response mux, one cycle after the strobe
    always_comb begin
        case (sel_q)
            sel_mem: begin
                host_rsp = mem_rsp;
            end
            sel_pp: begin
                host_rsp = pp_rsp;
            end
            default: begin
                // unmapped address, answer with zero data
                host_rsp = '{rdata: '0, done: strobe_q};
            end
        endcase
    end

endmodule

//--- hdl/data_memory.sv
`timescale 1ns/1ns

module data_memory #(
    parameter int MEMSIZE_W = 256
) (
    input  logic              core_clk,
    input  logic              arst_n,
    input  soc_pkg::bus_req_t req,
    output soc_pkg::bus_rsp_t rsp,
    output logic              active
);

    // word index width, at least one bit
    localparam int IDX_W = (MEMSIZE_W > 1) ? $clog2(MEMSIZE_W) : 1;

    // number of byte lanes per word
    localparam int LANES = $bits(soc_pkg::bus_mask_t);

    // first byte address past the array
    localparam soc_pkg::bus_addr_t MEM_BYTES = soc_pkg::bus_addr_t'(MEMSIZE_W * 4);

    soc_pkg::bus_data_t mem [MEMSIZE_W];
    soc_pkg::bus_data_t rdata_q;
    logic [IDX_W-1:0]   word_idx;
    logic               done_q;

    // claims the low end of the address map
    assign active = req.addr < MEM_BYTES;

    // word address, byte offset dropped
    assign word_idx = req.addr[IDX_W+1:2];

    // byte-masked write
    always_ff @(posedge core_clk) begin
        if (req.wen) begin
            for (int lane = 0; lane < LANES; lane++) begin
                if (req.wmask[lane]) begin
                    mem[word_idx][lane*8 +: 8] <= req.wdata[lane*8 +: 8];
                end
            end
        end
    end

    // registered read
    always_ff @(posedge core_clk) begin
        if (req.ren) begin
            rdata_q <= mem[word_idx];
        end
    end

    // done one cycle after either strobe
    always_ff @(posedge core_clk or negedge arst_n) begin
        if (!arst_n) begin
            done_q <= 1'b0;
        end else begin
            done_q <= req.ren | req.wen;
        end
    end

    assign rsp = '{rdata: rdata_q, done: done_q};

endmodule

//--- hdl/soc_hub75.sv
`timescale 1ns/1ns

module soc_hub75 #(
    parameter int MEMSIZE_W = 256
) (
    input  logic                 core_clk,
    input  logic                 arst_n,
    input  soc_pkg::bus_req_t    host_req,
    output soc_pkg::bus_rsp_t    host_rsp,
    output soc_pkg::hub75_pins_t panel,
    output logic                 led
);

    soc_pkg::bus_req_t  mem_req;
    soc_pkg::bus_rsp_t  mem_rsp;
    logic               mem_active;

    soc_pkg::bus_req_t  pp_req;
    soc_pkg::bus_rsp_t  pp_rsp;
    logic               pp_active;

    soc_pkg::bus_data_t port_io;

    bus_hub u_hub (
        .core_clk   (core_clk),
        .arst_n     (arst_n),
        .host_req   (host_req),
        .host_rsp   (host_rsp),
        .mem_req    (mem_req),
        .mem_rsp    (mem_rsp),
        .mem_active (mem_active),
        .pp_req     (pp_req),
        .pp_rsp     (pp_rsp),
        .pp_active  (pp_active)
    );

    data_memory #(
        .MEMSIZE_W (MEMSIZE_W)
    ) u_mem (
        .core_clk (core_clk),
        .arst_n   (arst_n),
        .req      (mem_req),
        .rsp      (mem_rsp),
        .active   (mem_active)
    );

    parallel_output u_pp (
        .core_clk (core_clk),
        .arst_n   (arst_n),
        .req      (pp_req),
        .rsp      (pp_rsp),
        .active   (pp_active),
        .io       (port_io)
    );

    // port bytes onto the panel
    always_comb begin
        // byte 1 drives the color lines
        panel.r0    = port_io[8];
        panel.r1    = port_io[9];
        panel.g0    = port_io[10];
        panel.g1    = port_io[11];
        panel.b0    = port_io[12];
        panel.b1    = port_io[13];

        // byte 2 drives row address and control
        panel.row_a = port_io[16];
        panel.row_b = port_io[17];
        panel.row_c = port_io[18];
        panel.row_d = port_io[19];
        panel.row_e = port_io[20];
        panel.stb   = port_io[21];
        panel.oe    = port_io[22];

        // byte 3 alone, so the shift clock toggles with a single byte write
        panel.clk   = port_io[24];
    end

    // status led is active low on the board
    assign led = ~port_io[0];

endmodule

//--- parallel_port/parallel_output.sv
`timescale 1ns/1ns

module parallel_output (
    input  logic               core_clk,
    input  logic               arst_n,
    input  soc_pkg::bus_req_t  req,
    output soc_pkg::bus_rsp_t  rsp,
    output logic               active,
    output soc_pkg::bus_data_t io
);

    localparam int LANES = $bits(soc_pkg::bus_mask_t);

    soc_pkg::bus_data_t io_q;
    logic               done_q;

    // single word at PP_BASE, byte offset ignored
    assign active = {req.addr[31:2], 2'b00} == soc_pkg::PP_BASE;

    // output register, byte lanes under wmask
    always_ff @(posedge core_clk or negedge arst_n) begin
        if (!arst_n) begin
            io_q <= '0;
        end else if (req.wen) begin
            for (int lane = 0; lane < LANES; lane++) begin
                if (req.wmask[lane]) begin
                    io_q[lane*8 +: 8] <= req.wdata[lane*8 +: 8];
                end
            end
        end
    end

    // done one cycle after either strobe
    always_ff @(posedge core_clk or negedge arst_n) begin
        if (!arst_n) begin
            done_q <= 1'b0;
        end else begin
            done_q <= req.ren | req.wen;
        end
    end

    // readback of the live register
    // a write in the previous cycle is already visible here
    assign rsp = '{rdata: io_q, done: done_q};

    assign io = io_q;

endmodule

//--- sources.f
+incdir+tb
common/soc_pkg.sv
hdl/bus_hub.sv
hdl/data_memory.sv
parallel_port/parallel_output.sv
hdl/soc_hub75.sv
tb/tb_soc_hub75.sv

//--- tb/tb_soc_checks.svh
`ifndef TB_SOC_CHECKS_SVH
`define TB_SOC_CHECKS_SVH

// access kind of one table entry
typedef enum logic {
    op_read,
    op_write
} op_e;

localparam int TIMEOUT_CYCLES = 20;

logic [31:0] lfsr_state = 32'hdfa2_5442;
int          errors     = 0;
int          checks     = 0;
int          timeouts   = 0;

// fibonacci lfsr, x^32 + x^22 + x^2 + x + 1
function automatic logic lfsr_step();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
endfunction

// one lfsr step per bit taken
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        v = {v[30:0], lfsr_step()};
    end
    return v;
endfunction

task automatic check_data(input string what, input soc_pkg::bus_data_t got,
                          input soc_pkg::bus_data_t exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("[FAIL] %0t ns: %s returned %h, expected %h", $time, what, got, exp);
    end
endtask

task automatic check_pins(input string what, input soc_pkg::hub75_pins_t got,
                          input soc_pkg::hub75_pins_t exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("[FAIL] %0t ns: %s panel pins %b, expected %b", $time, what, got, exp);
    end
endtask

task automatic check_led(input string what, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("[FAIL] %0t ns: %s led %b, expected %b", $time, what, got, exp);
    end
endtask

task automatic check_count(input string what, input int got, input int exp);
    checks++;
    if (got != exp) begin
        errors++;
        $display("[FAIL] %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
    end
endtask

// one request, strobe for a single cycle, then wait for done
// latency is -1 if done never came
task automatic bus_access(input op_e op, input soc_pkg::bus_addr_t addr,
                          input soc_pkg::bus_data_t data, input soc_pkg::bus_mask_t mask,
                          output soc_pkg::bus_data_t rdata, output int latency);
    soc_pkg::bus_req_t req;
    int                waited;
    req       = '0;
    req.addr  = addr;
    req.wdata = data;
    req.wmask = mask;
    req.wen   = (op == op_write);
    req.ren   = (op == op_read);
    rdata     = '0;
    latency   = -1;
    @(posedge core_clk);
    host_req <= req;
    // done in the strobe cycle itself would be too early
    @(negedge core_clk);
    if (host_rsp.done) begin
        latency = 0;
        rdata   = host_rsp.rdata;
    end
    @(posedge core_clk);
    host_req <= '0;
    if (latency < 0) begin
        waited = 0;
        do begin
            @(negedge core_clk);
            waited++;
        end while (!host_rsp.done && waited < TIMEOUT_CYCLES);
        if (host_rsp.done) begin
            latency = waited;
            rdata   = host_rsp.rdata;
        end else begin
            timeouts++;
            $display("timeout at %0t ns: no done within %0d cycles after the request to %h",
                     $time, TIMEOUT_CYCLES, addr);
        end
    end
endtask

`endif

//--- tb/tb_soc_hub75.sv
`timescale 1ns/1ns

module tb_soc_hub75;

    logic                 core_clk;
    logic                 arst_n;
    soc_pkg::bus_req_t    host_req;
    soc_pkg::bus_rsp_t    host_rsp;
    soc_pkg::hub75_pins_t panel;
    logic                 led;

    soc_hub75 dut (
        .core_clk (core_clk),
        .arst_n   (arst_n),
        .host_req (host_req),
        .host_rsp (host_rsp),
        .panel    (panel),
        .led      (led)
    );

    `include "tb_soc_checks.svh"

    typedef enum logic [1:0] {
        reg_none,
        reg_mem,
        reg_port
    } region_e;

    // exp_port is the port word once the entry is done
    typedef struct packed {
        op_e                op;
        soc_pkg::bus_addr_t addr;
        soc_pkg::bus_data_t data;
        soc_pkg::bus_mask_t mask;
        soc_pkg::bus_data_t exp_data;
        soc_pkg::bus_data_t exp_port;
    } entry_t;

    entry_t             stim_q[$];
    soc_pkg::bus_data_t ref_mem[];
    soc_pkg::bus_data_t ref_port;
    int                 mem_words;
    int                 tests_run = 0;

    initial begin
        core_clk = 1'b0;
        forever #20 core_clk = ~core_clk;
    end

    function automatic soc_pkg::bus_data_t merge_bytes(input soc_pkg::bus_data_t old,
                                                       input soc_pkg::bus_data_t wdata,
                                                       input soc_pkg::bus_mask_t mask);
        soc_pkg::bus_data_t v;
        v = old;
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) begin
                v[b*8 +: 8] = wdata[b*8 +: 8];
            end
        end
        return v;
    endfunction

    // preload pattern that depends on every address bit
    function automatic soc_pkg::bus_data_t fill_word(input soc_pkg::bus_addr_t a);
        return (a * 32'h9e37_79b9) ^ 32'h3c5a_a5c3;
    endfunction

    function automatic region_e region_of(input soc_pkg::bus_addr_t a);
        if (a < soc_pkg::bus_addr_t'(mem_words * 4)) begin
            return reg_mem;
        end else if ({a[31:2], 2'b00} == soc_pkg::PP_BASE) begin
            return reg_port;
        end
        return reg_none;
    endfunction

    // panel wiring of the port word
    function automatic soc_pkg::hub75_pins_t pins_of(input soc_pkg::bus_data_t w);
        soc_pkg::hub75_pins_t p;
        p.r0    = w[8];
        p.r1    = w[9];
        p.g0    = w[10];
        p.g1    = w[11];
        p.b0    = w[12];
        p.b1    = w[13];
        p.row_a = w[16];
        p.row_b = w[17];
        p.row_c = w[18];
        p.row_d = w[19];
        p.row_e = w[20];
        p.stb   = w[21];
        p.oe    = w[22];
        p.clk   = w[24];
        return p;
    endfunction

    // reference model runs as the table is built
    function automatic void add_entry(input op_e op, input soc_pkg::bus_addr_t addr,
                                      input soc_pkg::bus_data_t data,
                                      input soc_pkg::bus_mask_t mask);
        entry_t  e;
        region_e where;
        int      idx;
        where      = region_of(addr);
        idx        = int'(addr >> 2);
        e.op       = op;
        e.addr     = addr;
        e.data     = data;
        e.mask     = mask;
        e.exp_data = '0;
        if (op == op_write) begin
            if (where == reg_mem) begin
                ref_mem[idx] = merge_bytes(ref_mem[idx], data, mask);
            end else if (where == reg_port) begin
                ref_port = merge_bytes(ref_port, data, mask);
            end
        end else if (where == reg_mem) begin
            e.exp_data = ref_mem[idx];
        end else if (where == reg_port) begin
            e.exp_data = ref_port;
        end
        e.exp_port = ref_port;
        stim_q.push_back(e);
    endfunction

    function automatic void add_random(input int count);
        op_e                op;
        soc_pkg::bus_addr_t addr;
        soc_pkg::bus_addr_t offs;
        soc_pkg::bus_data_t data;
        soc_pkg::bus_mask_t mask;
        logic [1:0]         pick;
        for (int i = 0; i < count; i++) begin
            pick = rand_bits(2);
            op   = op_e'(rand_bits(1));
            offs = rand_bits(2);
            if (pick <= 2'd1) begin
                addr = rand_bits(16);
                addr = (addr % mem_words) * 4 + offs;
            end else if (pick == 2'd2) begin
                addr = soc_pkg::PP_BASE + offs;
            end else begin
                // just past the memory and below the port
                addr = rand_bits(16);
                addr = soc_pkg::bus_addr_t'(mem_words * 4) + addr * 4 + offs;
            end
            data = rand_bits(32);
            mask = rand_bits(4);
            add_entry(op, addr, data, mask);
        end
    endfunction

    task automatic run_table(input string name);
        int                 errs_before;
        int                 count;
        int                 latency;
        soc_pkg::bus_data_t rdata;
        entry_t             e;
        string              what;
        errs_before = errors;
        count       = 0;
        for (int i = 0; i < stim_q.size() && timeouts == 0; i++) begin
            e    = stim_q[i];
            what = $sformatf("%s entry %0d %s at %h", name, i,
                             (e.op == op_read) ? "read" : "write", e.addr);
            bus_access(e.op, e.addr, e.data, e.mask, rdata, latency);
            if (latency >= 0) begin
                check_count({what, " done latency"}, latency, 1);
                if (e.op == op_read) begin
                    check_data(what, rdata, e.exp_data);
                end
                check_pins(what, panel, pins_of(e.exp_port));
                check_led(what, led, ~e.exp_port[0]);
                count++;
            end
        end
        tests_run++;
        $display("test %0d %s: %0d of %0d entries applied, %0d mismatches",
                 tests_run, name, count, stim_q.size(), errors - errs_before);
        stim_q.delete();
    endtask

    initial begin
        soc_pkg::bus_addr_t last;
        soc_pkg::bus_addr_t past;
        int                 idle_done;
        int                 errs_before;
        host_req <= '0;
        arst_n   <= 1'b0;
        mem_words = dut.MEMSIZE_W;
        ref_mem   = new[mem_words];
        ref_port  = '0;
        last      = soc_pkg::bus_addr_t'((mem_words - 1) * 4);
        past      = soc_pkg::bus_addr_t'(mem_words * 4);
        repeat (2) @(posedge core_clk);
        arst_n <= 1'b1;

        // nothing should move while idle after reset
        errs_before = errors;
        idle_done   = 0;
        for (int i = 0; i < 4; i++) begin
            @(negedge core_clk);
            if (host_rsp.done) begin
                idle_done++;
            end
        end
        check_pins("after reset", panel, '0);
        check_led("after reset", led, 1'b1);
        check_count("done pulses while idle", idle_done, 0);
        tests_run++;
        $display("test %0d reset state: %0d mismatches", tests_run, errors - errs_before);

        for (int i = 0; i < mem_words; i++) begin
            add_entry(op_write, i * 4, fill_word(i * 4), 4'hf);
        end
        run_table("memory preload");

        add_entry(op_write, 32'h10, 32'h1122_3344, 4'hf);
        add_entry(op_read,  32'h10, '0, '0);
        add_entry(op_write, 32'h10, 32'haabb_ccdd, 4'b0101);
        add_entry(op_read,  32'h10, '0, '0);
        add_entry(op_write, 32'h11, 32'h5566_7788, 4'b1000);
        add_entry(op_read,  32'h12, '0, '0);
        add_entry(op_write, last, 32'hcafe_f00d, 4'b0011);
        add_entry(op_read,  last, '0, '0);
        add_entry(op_read,  32'h0, '0, '0);
        run_table("memory masks");

        add_entry(op_write, soc_pkg::PP_BASE, 32'h0000_0001, 4'hf);
        add_entry(op_write, soc_pkg::PP_BASE, 32'h017f_3f00, 4'b1110);
        add_entry(op_read,  soc_pkg::PP_BASE, '0, '0);
        add_entry(op_write, soc_pkg::PP_BASE + 2, 32'h0000_0000, 4'b0100);
        add_entry(op_read,  soc_pkg::PP_BASE, '0, '0);
        add_entry(op_write, soc_pkg::PP_BASE, 32'hffff_ffff, 4'b0001);
        add_entry(op_write, soc_pkg::PP_BASE, 32'h0000_2a00, 4'b0010);
        add_entry(op_read,  soc_pkg::PP_BASE + 3, '0, '0);
        run_table("port pins");

        add_entry(op_read,  past, '0, '0);
        add_entry(op_read,  soc_pkg::PP_BASE + 4, '0, '0);
        add_entry(op_read,  32'hffff_fffc, '0, '0);
        // lands on word 4 if the strobe leaked into the memory
        add_entry(op_write, past + 32'h10, 32'hdead_beef, 4'hf);
        add_entry(op_read,  32'h10, '0, '0);
        add_entry(op_write, soc_pkg::PP_BASE - 4, 32'hffff_ffff, 4'hf);
        add_entry(op_write, 32'h8010_0000, 32'h1234_5678, 4'hf);
        add_entry(op_read,  soc_pkg::PP_BASE, '0, '0);
        add_entry(op_read,  32'h0, '0, '0);
        run_table("unmapped");

        add_random(200);
        run_table("random mix");

        $display("tests %0d, checks %0d, mismatches %0d, timeouts %0d",
                 tests_run, checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
